// File: common/gen2_dec_pkg.sv
`default_nettype none

package gen2_dec_pkg;

	// command recognised from the leading code bits
	typedef enum logic [2:0]
	{
		CMD_NONE,
		CMD_QUERY_REP,      // 00
		CMD_ACK,            // 01
		CMD_QUERY,          // 1000, preamble frames only
		CMD_QUERY_ADJUST,   // 1001
		CMD_NAK,            // 11000000
		CMD_REQ_RN          // 11000001
	} cmd_e;

	// where we are inside the current frame
	typedef enum logic [2:0]
	{
		SEG_IDLE,
		SEG_NAME,
		SEG_DATA,
		SEG_HANDLE,
		SEG_CRC,
		SEG_DONE
	} seg_e;

	typedef logic [4:0]  bit_cnt_t;   // bits within one segment
	typedef logic [3:0]  q_t;         // slot-count exponent
	typedef logic [1:0]  session_t;
	typedef logic [1:0]  sel_t;
	typedef logic [1:0]  m_t;         // miller subcarrier cycles
	typedef logic [15:0] handle_t;

	// segment lengths fixed by the air protocol
	localparam bit_cnt_t QUERY_DATA_BITS        = 5'd13;
	localparam bit_cnt_t QUERY_ADJUST_DATA_BITS = 5'd5;
	localparam bit_cnt_t QUERY_REP_DATA_BITS    = 5'd2;
	localparam bit_cnt_t HANDLE_BITS            = 5'd16;
	localparam bit_cnt_t QUERY_CRC_BITS         = 5'd5;   // crc-5 on query only
	localparam bit_cnt_t CRC16_BITS             = 5'd16;

endpackage

`default_nettype wire

// File: design/cmd_name_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module cmd_name_decoder
(
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_valid,
	input  logic               i_data,
	input  logic               i_newcmd,
	input  logic               i_preamble,
	input  logic               i_name_phase,
	output gen2_dec_pkg::cmd_e o_cmd
);
	import gen2_dec_pkg::*;

	logic [7:0] code_buf;
	logic [3:0] code_cnt;
	logic [7:0] nxt_buf;
	logic [3:0] nxt_cnt;
	logic       take_bit;
	cmd_e       code_match;

	// only collect until a code is latched or 8 bits are in
	assign take_bit = i_valid && i_name_phase && (o_cmd == CMD_NONE) && (code_cnt < 4'd8);
	assign nxt_buf  = {code_buf[6:0], i_data};   // msb first
	assign nxt_cnt  = code_cnt + 4'd1;

	// codes are prefix free, so test only at the lengths that exist
	always_comb
	begin
		code_match = CMD_NONE;
		case (nxt_cnt)
			4'd2:
			begin
				if (nxt_buf[1:0] == 2'b00)
					code_match = CMD_QUERY_REP;
				else if (nxt_buf[1:0] == 2'b01)
					code_match = CMD_ACK;
			end
			4'd4:
			begin
				if (nxt_buf[3:0] == 4'b1000 && i_preamble)   // query needs full preamble
					code_match = CMD_QUERY;
				else if (nxt_buf[3:0] == 4'b1001)
					code_match = CMD_QUERY_ADJUST;
			end
			4'd8:
			begin
				if (nxt_buf == 8'hc0)
					code_match = CMD_NAK;
				else if (nxt_buf == 8'hc1)
					code_match = CMD_REQ_RN;
			end
			default:
				code_match = CMD_NONE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			code_buf <= '0;
			code_cnt <= '0;
			o_cmd    <= CMD_NONE;
		end
		else if (i_newcmd)   // new frame restarts the search
		begin
			code_buf <= '0;
			code_cnt <= '0;
			o_cmd    <= CMD_NONE;
		end
		else if (take_bit)
		begin
			code_buf <= nxt_buf;
			code_cnt <= nxt_cnt;
			if (code_match != CMD_NONE)
				o_cmd <= code_match;   // first match sticks
		end
	end

	// a latched command only goes away through a new frame
	a_cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
		(o_cmd != CMD_NONE && !i_newcmd) |=> (o_cmd == $past(o_cmd)))
		else $error("o_cmd changed without i_newcmd");

endmodule

`default_nettype wire

// File: design/frame_sequencer.sv
`default_nettype none
`timescale 1ns/10ps

module frame_sequencer
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_valid,
	input  logic                   i_data,
	input  logic                   i_newcmd,
	input  gen2_dec_pkg::cmd_e     i_cmd,
	output logic                   o_name_phase,
	output logic                   o_field_bit,
	output logic                   o_cmd_ok,
	output gen2_dec_pkg::bit_cnt_t o_bit_idx,
	output gen2_dec_pkg::handle_t  o_handle
);
	import gen2_dec_pkg::*;

	seg_e     state;
	seg_e     state_nxt;
	bit_cnt_t bit_cnt;
	bit_cnt_t seg_len;
	logic     counting;
	logic     seg_last;

	assign counting = (state == SEG_DATA) || (state == SEG_HANDLE) || (state == SEG_CRC);
	assign seg_last = counting && i_valid && (bit_cnt == seg_len - 5'd1);   // final bit strobe

	// length of the segment being received
	always_comb
	begin
		case (state)
			SEG_DATA:
			begin
				case (i_cmd)
					CMD_QUERY:        seg_len = QUERY_DATA_BITS;
					CMD_QUERY_ADJUST: seg_len = QUERY_ADJUST_DATA_BITS;
					CMD_QUERY_REP:    seg_len = QUERY_REP_DATA_BITS;
					default:          seg_len = '0;
				endcase
			end
			SEG_HANDLE:
				seg_len = HANDLE_BITS;
			SEG_CRC:
				seg_len = (i_cmd == CMD_QUERY) ? QUERY_CRC_BITS : CRC16_BITS;
			default:
				seg_len = '0;
		endcase
	end

	always_comb
	begin
		state_nxt = state;
		if (i_newcmd)
			state_nxt = SEG_NAME;   // any state, a new frame starts over
		else
		begin
			case (state)
				SEG_IDLE:
					state_nxt = SEG_IDLE;
				SEG_NAME:
				begin
					if (i_cmd == CMD_NAK)
						state_nxt = SEG_DONE;   // nak carries nothing else
					else if (i_cmd == CMD_ACK || i_cmd == CMD_REQ_RN)
						state_nxt = SEG_HANDLE;
					else if (i_cmd != CMD_NONE)
						state_nxt = SEG_DATA;
				end
				SEG_DATA:
				begin
					if (seg_last)
						state_nxt = (i_cmd == CMD_QUERY) ? SEG_CRC : SEG_DONE;
				end
				SEG_HANDLE:
				begin
					if (seg_last)
						state_nxt = (i_cmd == CMD_REQ_RN) ? SEG_CRC : SEG_DONE;
				end
				SEG_CRC:
				begin
					if (seg_last)
						state_nxt = SEG_DONE;   // crc is counted, not checked
				end
				default:
					state_nxt = SEG_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= SEG_IDLE;
		else
			state <= state_nxt;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			bit_cnt <= '0;
		else if (state_nxt != state)
			bit_cnt <= '0;   // fresh count per segment
		else if (counting && i_valid)
			bit_cnt <= bit_cnt + 5'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_handle <= '0;
		else if (state == SEG_HANDLE && i_valid)
			o_handle <= {o_handle[14:0], i_data};
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_cmd_ok <= 1'b0;
		else
			o_cmd_ok <= (state == SEG_DONE);
	end

	assign o_name_phase = (state == SEG_NAME);
	assign o_field_bit  = i_valid && (state == SEG_DATA);
	assign o_bit_idx    = bit_cnt;

	a_cnt_in_range: assert property (@(posedge clk) disable iff (!rst_n)
		counting |-> (bit_cnt <= seg_len))
		else $error("bit counter ran past segment length");

	a_ok_single: assert property (@(posedge clk) disable iff (!rst_n)
		o_cmd_ok |=> !o_cmd_ok)
		else $error("o_cmd_ok high for two cycles");

endmodule

`default_nettype wire

// File: design/inventory_field_extract.sv
`default_nettype none
`timescale 1ns/10ps

module inventory_field_extract
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_field_bit,
	input  logic                   i_data,
	input  gen2_dec_pkg::bit_cnt_t i_bit_idx,
	input  gen2_dec_pkg::cmd_e     i_cmd,
	output logic                   o_dr,
	output logic                   o_trext,
	output logic                   o_target,
	output logic                   o_session_done,
	output logic                   o_inventory,
	output gen2_dec_pkg::m_t       o_m,
	output gen2_dec_pkg::sel_t     o_sel,
	output gen2_dec_pkg::session_t o_session,
	output gen2_dec_pkg::session_t o_session2,
	output gen2_dec_pkg::q_t       o_q
);
	import gen2_dec_pkg::*;

	logic query_bit;
	logic adjust_bit;
	logic rep_bit;

	assign query_bit  = i_field_bit && (i_cmd == CMD_QUERY);
	assign adjust_bit = i_field_bit && (i_cmd == CMD_QUERY_ADJUST);
	assign rep_bit    = i_field_bit && (i_cmd == CMD_QUERY_REP);

	// query parameters, one field per data bit position
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_dr      <= 1'b0;
			o_m       <= '0;
			o_trext   <= 1'b0;
			o_sel     <= '0;
			o_session <= '0;
			o_target  <= 1'b0;
		end
		else if (query_bit)
		begin
			case (i_bit_idx)
				5'd0:       o_dr      <= i_data;
				5'd1, 5'd2: o_m       <= {o_m[0], i_data};
				5'd3:       o_trext   <= i_data;
				5'd4, 5'd5: o_sel     <= {o_sel[0], i_data};
				5'd6, 5'd7: o_session <= {o_session[0], i_data};
				5'd8:       o_target  <= i_data;
				default:    o_target  <= o_target;   // q handled below
			endcase
		end
	end

	// q is loaded by query and nudged by queryadjust
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_q <= '0;
		else if (query_bit && i_bit_idx >= 5'd9)
			o_q <= {o_q[2:0], i_data};
		else if (adjust_bit && i_data && i_bit_idx == 5'd2)
			o_q <= o_q + 4'd1;   // wraps at 16
		else if (adjust_bit && i_data && i_bit_idx == 5'd4)
			o_q <= o_q - 4'd1;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_session2 <= '0;
		else if ((adjust_bit || rep_bit) && i_bit_idx < 5'd2)
			o_session2 <= {o_session2[0], i_data};
	end

	// session bits are complete by the time target arrives
	assign o_session_done = query_bit && (i_bit_idx == 5'd8);

	assign o_inventory = (i_cmd == CMD_QUERY) || (i_cmd == CMD_QUERY_ADJUST) ||
		(i_cmd == CMD_QUERY_REP);

endmodule

`default_nettype wire

// File: design/gen2_cmd_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module gen2_cmd_decoder
(
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   i_valid,
	input  logic                   i_data,
	input  logic                   i_newcmd,
	input  logic                   i_preamble,
	output gen2_dec_pkg::cmd_e     o_cmd,
	output logic                   o_cmd_ok,
	output gen2_dec_pkg::handle_t  o_handle,
	output logic                   o_dr,
	output logic                   o_trext,
	output logic                   o_target,
	output logic                   o_session_done,
	output logic                   o_inventory,
	output gen2_dec_pkg::m_t       o_m,
	output gen2_dec_pkg::sel_t     o_sel,
	output gen2_dec_pkg::session_t o_session,
	output gen2_dec_pkg::session_t o_session2,
	output gen2_dec_pkg::q_t       o_q
);
	import gen2_dec_pkg::*;

	logic     name_phase;
	logic     field_bit;
	bit_cnt_t bit_idx;

	cmd_name_decoder u_name
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.i_newcmd     (i_newcmd),
		.i_preamble   (i_preamble),
		.i_name_phase (name_phase),
		.o_cmd        (o_cmd)
	);

	frame_sequencer u_seq
	(
		.clk          (clk),
		.rst_n        (rst_n),
		.i_valid      (i_valid),
		.i_data       (i_data),
		.i_newcmd     (i_newcmd),
		.i_cmd        (o_cmd),
		.o_name_phase (name_phase),
		.o_field_bit  (field_bit),
		.o_cmd_ok     (o_cmd_ok),
		.o_bit_idx    (bit_idx),
		.o_handle     (o_handle)
	);

	inventory_field_extract u_fields
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.i_field_bit    (field_bit),
		.i_data         (i_data),
		.i_bit_idx      (bit_idx),
		.i_cmd          (o_cmd),
		.o_dr           (o_dr),
		.o_trext        (o_trext),
		.o_target       (o_target),
		.o_session_done (o_session_done),
		.o_inventory    (o_inventory),
		.o_m            (o_m),
		.o_sel          (o_sel),
		.o_session      (o_session),
		.o_session2     (o_session2),
		.o_q            (o_q)
	);

endmodule

`default_nettype wire

// File: dv/gen2_stim.svh
`ifndef GEN2_STIM_SVH
`define GEN2_STIM_SVH

logic [31:0] lfsr_state;
logic        frame_bits[$];   // bits of the frame being sent, first bit first

// register contents the tag should hold
logic     mdl_dr;
m_t       mdl_m;
logic     mdl_trext;
sel_t     mdl_sel;
session_t mdl_session;
logic     mdl_target;
q_t       mdl_q;
session_t mdl_session2;
handle_t  mdl_handle;

// fibonacci lfsr, taps 32 22 2 1
function automatic logic rand_bit();
	logic fb;
	fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
	lfsr_state = {lfsr_state[30:0], fb};
	return fb;
endfunction

function automatic logic [15:0] rand_bits(input int n);
	logic [15:0] v;
	v = '0;
	for (int i = 0; i < n; i++)
		v = {v[14:0], rand_bit()};   // one step per bit
	return v;
endfunction

task automatic push_bits(input logic [15:0] v, input int n);
	for (int i = n - 1; i >= 0; i--)
		frame_bits.push_back(v[i]);   // msb goes out first
endtask

task automatic model_reset();
	mdl_dr       = 1'b0;
	mdl_m        = '0;
	mdl_trext    = 1'b0;
	mdl_sel      = '0;
	mdl_session  = '0;
	mdl_target   = 1'b0;
	mdl_q        = '0;
	mdl_session2 = '0;
	mdl_handle   = '0;
endtask

// builds one frame and moves the model along for recognised commands
task automatic build_frame(input logic [2:0] kind, output cmd_e exp_cmd, output logic pre);
	logic [15:0] d;
	frame_bits.delete();
	exp_cmd = CMD_NONE;
	pre     = 1'b0;
	case (kind)
		3'd0:
		begin
			exp_cmd = CMD_QUERY_REP;
			push_bits(16'h0, 2);
			d = rand_bits(2);
			push_bits(d, 2);
			mdl_session2 = d[1:0];
		end
		3'd1, 3'd5:
		begin
			exp_cmd = (kind == 3'd1) ? CMD_ACK : CMD_REQ_RN;
			if (kind == 3'd1)
				push_bits(16'h1, 2);
			else
				push_bits(16'hc1, 8);
			d = rand_bits(16);
			push_bits(d, 16);
			mdl_handle = d;
			if (kind == 3'd5)
				push_bits(rand_bits(16), 16);   // crc-16 trailer
		end
		3'd2, 3'd6:
		begin
			pre = (kind == 3'd2);   // kind 6 is a query code with no preamble
			push_bits(16'h8, 4);
			d = rand_bits(13);
			push_bits(d, 13);
			push_bits(rand_bits(5), 5);
			if (kind == 3'd2)
			begin
				exp_cmd     = CMD_QUERY;
				mdl_dr      = d[12];
				mdl_m       = d[11:10];
				mdl_trext   = d[9];
				mdl_sel     = d[8:7];
				mdl_session = d[6:5];
				mdl_target  = d[4];
				mdl_q       = d[3:0];
			end
		end
		3'd3:
		begin
			exp_cmd = CMD_QUERY_ADJUST;
			push_bits(16'h9, 4);
			d = rand_bits(5);
			push_bits(d, 5);
			mdl_session2 = d[4:3];
			mdl_q        = mdl_q + {3'b000, d[2]} - {3'b000, d[0]};   // mod 16
		end
		3'd4:
		begin
			exp_cmd = CMD_NAK;
			push_bits(16'hc0, 8);
		end
		default:
		begin
			push_bits(16'ha, 4);   // 1010 is no known code
			push_bits(rand_bits(4), 4);
		end
	endcase
endtask

`endif

// File: dv/tb_gen2_cmd_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module tb_gen2_cmd_decoder;
	import gen2_dec_pkg::*;

	localparam int N_FRAMES   = 300;
	localparam int MAX_CYCLES = N_FRAMES * 42 * 5 + 2000;

	logic     clk = 1'b0;
	logic     rst_n;
	logic     i_valid;
	logic     i_data;
	logic     i_newcmd;
	logic     i_preamble;
	cmd_e     o_cmd;
	logic     o_cmd_ok;
	handle_t  o_handle;
	logic     o_dr;
	logic     o_trext;
	logic     o_target;
	logic     o_session_done;
	logic     o_inventory;
	m_t       o_m;
	sel_t     o_sel;
	session_t o_session;
	session_t o_session2;
	q_t       o_q;

	int    err_cnt;
	int    check_cnt;
	int    cyc_cnt;
	int    ok_cnt;
	int    ok_cyc;
	int    sd_cnt;
	int    last_bit_cyc;
	string test_tag;

	`include "gen2_stim.svh"

	gen2_cmd_decoder u_dut
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.i_valid        (i_valid),
		.i_data         (i_data),
		.i_newcmd       (i_newcmd),
		.i_preamble     (i_preamble),
		.o_cmd          (o_cmd),
		.o_cmd_ok       (o_cmd_ok),
		.o_handle       (o_handle),
		.o_dr           (o_dr),
		.o_trext        (o_trext),
		.o_target       (o_target),
		.o_session_done (o_session_done),
		.o_inventory    (o_inventory),
		.o_m            (o_m),
		.o_sel          (o_sel),
		.o_session      (o_session),
		.o_session2     (o_session2),
		.o_q            (o_q)
	);

	initial
	begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cyc_cnt <= cyc_cnt + 1;
		if (cyc_cnt >= MAX_CYCLES)
		begin
			$display("run stopped, frames still going after %0d cycles", MAX_CYCLES);
			$display("checks %0d, errors %0d", check_cnt, err_cnt + 1);
			$display("TB FAILED");
			$finish;
		end
	end

	// registered pulse, counted mid cycle away from the clock edge
	always @(negedge clk)
	begin
		if (rst_n === 1'b1 && o_cmd_ok === 1'b1)
		begin
			ok_cnt = ok_cnt + 1;
			ok_cyc = cyc_cnt;
		end
	end

	// follows the bit strobe, so taken at the edge that ends the strobe
	always @(posedge clk)
	begin
		if (rst_n === 1'b1 && o_session_done === 1'b1)
			sd_cnt = sd_cnt + 1;
	end

	task automatic compare_field(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		check_cnt++;
		if (exp !== act)
		begin
			err_cnt++;
			$display("Fail %s %s: expected %0h, actual %0h", test_tag, name, exp, act);
		end
	endtask

	// one strobe, then four quiet cycles
	task automatic send_bit(input logic b, input logic last);
		@(negedge clk);
		i_valid <= 1'b1;
		i_data  <= b;
		if (last)
			last_bit_cyc = cyc_cnt;
		@(negedge clk);
		i_valid <= 1'b0;
		i_data  <= 1'b0;
		repeat (3) @(negedge clk);
	endtask

	task automatic send_frame(input logic pre);
		ok_cnt = 0;
		sd_cnt = 0;
		@(negedge clk);
		i_newcmd   <= 1'b1;
		i_preamble <= pre;
		@(negedge clk);
		i_newcmd <= 1'b0;
		for (int i = 0; i < frame_bits.size(); i++)
			send_bit(frame_bits[i], i == frame_bits.size() - 1);
	endtask

	// a recognised frame ends on o_cmd_ok, others get a quiet window
	task automatic wait_frame_end(input logic expect_ok);
		int n;
		n = 0;
		@(posedge clk);
		while (n < 8 && (ok_cnt == 0 || !expect_ok))
		begin
			@(posedge clk);
			n++;
		end
	endtask

	task automatic check_frame(input cmd_e exp_cmd);
		logic done_exp;
		logic inv_exp;
		int   lat;
		done_exp = (exp_cmd != CMD_NONE);
		inv_exp  = (exp_cmd == CMD_QUERY) || (exp_cmd == CMD_QUERY_ADJUST) ||
			(exp_cmd == CMD_QUERY_REP);
		lat      = ok_cyc - last_bit_cyc;
		compare_field("o_cmd", exp_cmd, o_cmd);
		compare_field("o_cmd_ok count", done_exp, ok_cnt);
		if (done_exp && ok_cnt == 1 && (lat < 1 || lat > 3))
		begin
			err_cnt++;
			$display("%s: o_cmd_ok came %0d cycles after the last bit", test_tag, lat);
		end
		compare_field("o_session_done count", exp_cmd == CMD_QUERY, sd_cnt);
		compare_field("o_inventory", inv_exp, o_inventory);
		compare_field("o_dr", mdl_dr, o_dr);
		compare_field("o_m", mdl_m, o_m);
		compare_field("o_trext", mdl_trext, o_trext);
		compare_field("o_sel", mdl_sel, o_sel);
		compare_field("o_session", mdl_session, o_session);
		compare_field("o_target", mdl_target, o_target);
		compare_field("o_q", mdl_q, o_q);
		compare_field("o_session2", mdl_session2, o_session2);
		compare_field("o_handle", mdl_handle, o_handle);
	endtask

	initial
	begin
		cmd_e        exp_cmd;
		logic        pre;
		logic [15:0] kind;
		rst_n      = 1'b0;
		i_valid    = 1'b0;
		i_data     = 1'b0;
		i_newcmd   = 1'b0;
		i_preamble = 1'b0;
		lfsr_state = 32'h10bd_e17a;
		model_reset();
		repeat (10) @(negedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_tag = "reset";
		check_frame(CMD_NONE);   // everything cleared
		for (int f = 0; f < N_FRAMES; f++)
		begin
			test_tag = $sformatf("frame %0d", f);
			kind     = rand_bits(3);
			build_frame(kind[2:0], exp_cmd, pre);
			send_frame(pre);
			wait_frame_end(exp_cmd != CMD_NONE);
			check_frame(exp_cmd);
		end
		$display("checks %0d, errors %0d", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+dv
common/gen2_dec_pkg.sv
design/cmd_name_decoder.sv
design/frame_sequencer.sv
design/inventory_field_extract.sv
design/gen2_cmd_decoder.sv
dv/tb_gen2_cmd_decoder.sv
